// File: hw/lsu_pkg.sv
// the byte size has two codes and both decode the same everywhere in the LSU
package lsu_pkg;

  localparam int unsigned XLEN = 32;  // core data and address width

  //////////////////////////////////////////////////
  // access size, core encoding
  //////////////////////////////////////////////////
  typedef enum logic [1:0] {
    LSU_WORD   = 2'b00,
    LSU_HALF   = 2'b01,
    LSU_BYTE   = 2'b10,
    LSU_BYTE_X = 2'b11   // alias code for a byte
  } lsu_size_e;

  //////////////////////////////////////////////////
  // command and response ports
  //////////////////////////////////////////////////

  // one access as it arrives from the core side
  typedef struct packed {
    logic            we;        // store when set
    lsu_size_e       size;
    logic            sign_ext;  // only looked at for loads
    logic [XLEN-1:0] base;
    logic [XLEN-1:0] offset;    // added to base for the byte address
    logic [XLEN-1:0] wdata;     // narrow stores take the low bytes
  } lsu_cmd_t;

  // completion of one access
  typedef struct packed {
    logic [XLEN-1:0] rdata;      // extended load data, zero for a store
    logic            was_store;
  } lsu_rsp_t;

endpackage

// File: hw/mem_bus_pkg.sv
// word memory behind a byte address bus and address bits above the array are ignored
package mem_bus_pkg;

  localparam int unsigned MEM_WORDS = 256;                // memory depth in words
  localparam int unsigned MEM_AW    = $clog2(MEM_WORDS);  // word index width

  // request side, held with stable fields until gnt
  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;     // one bit per byte lane
    logic [31:0] addr;   // byte address
    logic [31:0] wdata;  // already rotated onto its lanes
  } mem_req_t;

  // response side
  typedef struct packed {
    logic        gnt;
    logic        rvalid;  // one cycle after gnt
    logic [31:0] rdata;
  } mem_rsp_t;

endpackage

// File: hw/lsu_align.sv
// combinational only and the read side expects the attributes captured at the grant
module lsu_align (
  // write side, current part
  input  lsu_pkg::lsu_size_e size_i,
  input  logic [1:0]         addr_lo_i,      // low bits of the bus address
  input  logic [1:0]         reg_offset_i,   // first part offset, zero outside a second part
  input  logic               second_part_i,
  input  logic [31:0]        wdata_i,
  output logic [3:0]         be_o,
  output logic [31:0]        wdata_o,
  // read side, granted part
  input  lsu_pkg::lsu_size_e rsize_i,
  input  logic [1:0]         roffset_i,
  input  logic               rsign_ext_i,
  input  logic [31:0]        rdata_i,
  input  logic [31:0]        prev_rdata_i,   // raw word of the first part
  output logic [31:0]        rdata_o
);
  import lsu_pkg::*;

  logic [1:0]  wrot;     // lane rotation of store data
  logic [31:0] rdata_w;  // word, joined across the boundary
  logic [15:0] rdata_h;
  logic [7:0]  rdata_b;

  //////////////////////////////////////////////////
  // byte enables
  //////////////////////////////////////////////////
  always_comb begin
    be_o = 4'b0000;
    case (size_i)
      LSU_WORD: begin
        if (!second_part_i) begin
          be_o = 4'b1111 << addr_lo_i;       // 1111 1110 1100 1000
        end else begin
          be_o = ~(4'b1111 << reg_offset_i); // the lanes the first part missed
        end
      end
      LSU_HALF: begin
        if (!second_part_i) begin
          be_o = 4'b0011 << addr_lo_i;       // offset 3 keeps only lane 3
        end else begin
          be_o = 4'b0001;                    // upper byte lands in lane 0
        end
      end
      LSU_BYTE, LSU_BYTE_X: be_o = 4'b0001 << addr_lo_i;
      default: be_o = 4'b0000;
    endcase
  end

  // byte 0 of the register goes to lane wrot
  // the second part keeps the rotation of the first since its address offset is zero
  assign wrot = addr_lo_i + reg_offset_i;

  always_comb begin
    case (wrot)
      2'b00:   wdata_o = wdata_i;
      2'b01:   wdata_o = {wdata_i[23:0], wdata_i[31:24]};
      2'b10:   wdata_o = {wdata_i[15:0], wdata_i[31:16]};
      default: wdata_o = {wdata_i[7:0],  wdata_i[31:8]};
    endcase
  end

  //////////////////////////////////////////////////
  // load data
  //////////////////////////////////////////////////
  always_comb begin
    case (roffset_i)
      2'b00:   rdata_w = rdata_i;
      2'b01:   rdata_w = {rdata_i[7:0],  prev_rdata_i[31:8]};
      2'b10:   rdata_w = {rdata_i[15:0], prev_rdata_i[31:16]};
      default: rdata_w = {rdata_i[23:0], prev_rdata_i[31:24]};
    endcase
  end

  always_comb begin
    case (roffset_i)
      2'b00:   rdata_h = rdata_i[15:0];
      2'b01:   rdata_h = rdata_i[23:8];
      2'b10:   rdata_h = rdata_i[31:16];
      default: rdata_h = {rdata_i[7:0], prev_rdata_i[31:24]}; // split half word
    endcase
  end

  assign rdata_b = rdata_i[{roffset_i, 3'b000} +: 8]; // bytes never split

  // zero or sign extension by captured size
  always_comb begin
    case (rsize_i)
      LSU_WORD: rdata_o = rdata_w;
      LSU_HALF: rdata_o = {{16{rsign_ext_i & rdata_h[15]}}, rdata_h};
      default:  rdata_o = {{24{rsign_ext_i & rdata_b[7]}}, rdata_b};
    endcase
  end

endmodule

// File: hw/lsu_core.sv
// one access in flight and a split access always runs as two bus parts with no errors modelled
module lsu_core (
  input  logic                  clk,
  input  logic                  rst_n,
  // from the ex stage
  input  logic                  data_req_i,
  input  logic                  data_we_i,
  input  lsu_pkg::lsu_size_e    data_size_i,
  input  logic                  data_sign_ext_i,
  input  logic [31:0]           data_wdata_i,
  input  logic [31:0]           data_addr_i,
  input  logic [1:0]            data_reg_offset_i,
  // to the ex stage
  output logic                  update_addr_o,  // current part granted
  output logic                  misaligned_o,   // next address is the second part
  output logic                  data_valid_o,   // access complete
  output logic [31:0]           data_rdata_o,
  // data bus
  output mem_bus_pkg::mem_req_t bus_req_o,
  input  mem_bus_pkg::mem_rsp_t bus_rsp_i
);
  import lsu_pkg::*;

  typedef enum logic [2:0] {
    IDLE, WAIT_GNT_MIS, WAIT_RVALID_MIS, WAIT_GNT, WAIT_RVALID
  } ls_fsm_e;

  ls_fsm_e     state_q, state_d;
  logic        second_q;    // second part of a split access
  logic        mis_det;     // current request needs a second part
  logic        req;
  lsu_size_e   size_q;      // attributes of the granted part
  logic [1:0]  offset_q;
  logic        sign_ext_q;
  logic        we_q;
  logic [31:0] rdata_q;     // raw first word of a split load
  logic [3:0]  be;
  logic [31:0] wdata_rot;
  logic [31:0] rdata_ext;

  //////////////////////////////////////////////////
  // split detection
  //////////////////////////////////////////////////
  always_comb begin
    mis_det = 1'b0;
    if (data_req_i && !second_q) begin
      case (data_size_i)
        LSU_WORD: mis_det = (data_addr_i[1:0] != 2'b00);
        LSU_HALF: mis_det = (data_addr_i[1:0] == 2'b11);
        default:  mis_det = 1'b0;  // bytes always fit
      endcase
    end
  end

  //////////////////////////////////////////////////
  // request / grant / rvalid FSM
  //////////////////////////////////////////////////
  always_comb begin
    state_d       = state_q;
    req           = 1'b0;
    update_addr_o = 1'b0;
    misaligned_o  = 1'b0;
    data_valid_o  = 1'b0;
    case (state_q)
      IDLE: begin
        if (data_req_i) begin
          req          = 1'b1;
          misaligned_o = mis_det;
          if (bus_rsp_i.gnt) begin
            update_addr_o = 1'b1;
            state_d       = mis_det ? WAIT_RVALID_MIS : WAIT_RVALID;
          end else begin
            state_d       = mis_det ? WAIT_GNT_MIS : WAIT_GNT;
          end
        end
      end
      WAIT_GNT_MIS: begin
        req          = 1'b1;    // held until granted
        misaligned_o = 1'b1;
        if (bus_rsp_i.gnt) begin
          update_addr_o = 1'b1;
          state_d       = WAIT_RVALID_MIS;
        end
      end
      WAIT_RVALID_MIS: begin
        // second part goes out the cycle after this rvalid
        if (bus_rsp_i.rvalid) begin
          state_d = WAIT_GNT;
        end
      end
      WAIT_GNT: begin
        req = 1'b1;
        if (bus_rsp_i.gnt) begin
          update_addr_o = 1'b1;
          state_d       = WAIT_RVALID;
        end
      end
      WAIT_RVALID: begin
        if (bus_rsp_i.rvalid) begin
          data_valid_o = 1'b1;  // last part, result leaves this cycle
          state_d      = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= IDLE;
      second_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == WAIT_RVALID_MIS && bus_rsp_i.rvalid) begin
        second_q <= 1'b1;
      end else if (data_valid_o) begin
        second_q <= 1'b0;
      end
    end
  end

  // read side needs these one cycle after the grant
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      size_q     <= LSU_WORD;
      offset_q   <= 2'b00;
      sign_ext_q <= 1'b0;
      we_q       <= 1'b0;
    end else if (update_addr_o) begin
      size_q     <= data_size_i;
      offset_q   <= second_q ? data_reg_offset_i : data_addr_i[1:0]; // keep the first offset
      sign_ext_q <= data_sign_ext_i;
      we_q       <= data_we_i;
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == WAIT_RVALID_MIS && bus_rsp_i.rvalid && !we_q) begin
      rdata_q <= bus_rsp_i.rdata;  // joined with the second word later
    end
  end

  lsu_align u_align (
    .size_i        (data_size_i),
    .addr_lo_i     (data_addr_i[1:0]),
    .reg_offset_i  (data_reg_offset_i),
    .second_part_i (second_q),
    .wdata_i       (data_wdata_i),
    .be_o          (be),
    .wdata_o       (wdata_rot),
    .rsize_i       (size_q),
    .roffset_i     (offset_q),
    .rsign_ext_i   (sign_ext_q),
    .rdata_i       (bus_rsp_i.rdata),
    .prev_rdata_i  (rdata_q),
    .rdata_o       (rdata_ext)
  );

  always_comb begin
    bus_req_o.req   = req;
    bus_req_o.we    = data_we_i;
    bus_req_o.be    = be;
    bus_req_o.addr  = data_addr_i;  // lane bits kept, memory ignores them
    bus_req_o.wdata = wdata_rot;
  end

  assign data_rdata_o = rdata_ext;

endmodule

// File: hw/lsu_ex_stage.sv
// holds one command at a time and the response has no ready so it must be taken when valid
module lsu_ex_stage (
  input  logic               clk,
  input  logic               rst_n,
  // command and response ports
  input  logic               cmd_valid_i,
  output logic               cmd_ready_o,
  input  lsu_pkg::lsu_cmd_t  cmd_i,
  output logic               rsp_valid_o,
  output lsu_pkg::lsu_rsp_t  rsp_o,
  // to the LSU core
  output logic               lsu_req_o,
  output logic               lsu_we_o,
  output lsu_pkg::lsu_size_e lsu_size_o,
  output logic               lsu_sign_ext_o,
  output logic [31:0]        lsu_wdata_o,
  output logic [31:0]        lsu_addr_o,
  output logic [1:0]         lsu_reg_offset_o,
  // from the LSU core
  input  logic               lsu_update_addr_i,
  input  logic               lsu_misaligned_i,
  input  logic               lsu_valid_i,
  input  logic [31:0]        lsu_rdata_i
);
  import lsu_pkg::*;

  logic            accept;
  logic            req_q;         // access held
  logic            we_q;
  lsu_size_e       size_q;
  logic            sign_ext_q;
  logic [XLEN-1:0] addr_q;        // byte address of the current part
  logic [1:0]      reg_offset_q;  // first part offset during a second part
  logic [XLEN-1:0] wdata_q;

  assign cmd_ready_o = ~req_q;
  assign accept      = cmd_valid_i & cmd_ready_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_q        <= 1'b0;
      we_q         <= 1'b0;
      size_q       <= LSU_WORD;
      sign_ext_q   <= 1'b0;
      addr_q       <= '0;
      reg_offset_q <= 2'b00;
    end else if (accept) begin
      req_q        <= 1'b1;          // request rises the cycle after accept
      we_q         <= cmd_i.we;
      size_q       <= cmd_i.size;
      sign_ext_q   <= cmd_i.sign_ext;
      addr_q       <= cmd_i.base + cmd_i.offset;
      reg_offset_q <= 2'b00;
    end else begin
      if (lsu_valid_i) begin
        req_q <= 1'b0;
      end
      // first part granted so step to the next aligned word
      if (lsu_update_addr_i && lsu_misaligned_i) begin
        addr_q       <= {addr_q[31:2] + 30'd1, 2'b00};
        reg_offset_q <= addr_q[1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      wdata_q <= cmd_i.wdata;
    end
  end

  assign lsu_req_o        = req_q;
  assign lsu_we_o         = we_q;
  assign lsu_size_o       = size_q;
  assign lsu_sign_ext_o   = sign_ext_q;
  assign lsu_wdata_o      = wdata_q;
  assign lsu_addr_o       = addr_q;
  assign lsu_reg_offset_o = reg_offset_q;

  // single cycle response in the core's valid cycle
  assign rsp_valid_o = req_q & lsu_valid_i;

  always_comb begin
    rsp_o.rdata     = we_q ? '0 : lsu_rdata_i;  // plain ack for stores
    rsp_o.was_store = we_q;
  end

endmodule

// File: hw/data_mem.sv
// array is not reset and the word index wraps every MEM_WORDS words
module data_mem (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  stall_i,   // holds back grants
  input  mem_bus_pkg::mem_req_t req_i,
  output mem_bus_pkg::mem_rsp_t rsp_o
);
  import mem_bus_pkg::*;

  logic [31:0]       mem_q [MEM_WORDS];
  logic [MEM_AW-1:0] idx;       // word index
  logic              gnt;
  logic              rvalid_q;
  logic [31:0]       rdata_q;

  assign idx = req_i.addr[MEM_AW+1:2];
  assign gnt = req_i.req & ~stall_i;  // grant in any cycle without stall

  // access happens in the grant cycle
  always_ff @(posedge clk) begin
    if (gnt && req_i.we) begin
      for (int b = 0; b < 4; b++) begin
        if (req_i.be[b]) begin
          mem_q[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];  // enabled lanes only
        end
      end
    end
    if (gnt) begin
      rdata_q <= mem_q[idx];  // old contents on a write
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= gnt;  // exactly one cycle after the grant
    end
  end

  always_comb begin
    rsp_o.gnt    = gnt;
    rsp_o.rvalid = rvalid_q;
    rsp_o.rdata  = rdata_q;
  end

endmodule

// File: hw/lsu_subsys_top.sv
// one command in flight and rsp_valid_o pulses once per command with no back-pressure
module lsu_subsys_top (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              cmd_valid_i,
  output logic              cmd_ready_o,
  input  lsu_pkg::lsu_cmd_t cmd_i,
  output logic              rsp_valid_o,
  output lsu_pkg::lsu_rsp_t rsp_o,
  input  logic              stall_i      // bus back-pressure
);
  import lsu_pkg::*;
  import mem_bus_pkg::*;

  //////////////////////////////////////////////////
  // ex stage to LSU core
  //////////////////////////////////////////////////
  logic        lsu_req;
  logic        lsu_we;
  lsu_size_e   lsu_size;
  logic        lsu_sign_ext;
  logic [31:0] lsu_wdata;
  logic [31:0] lsu_addr;
  logic [1:0]  lsu_reg_offset;
  logic        lsu_update_addr;
  logic        lsu_misaligned;
  logic        lsu_valid;
  logic [31:0] lsu_rdata;

  // data bus
  mem_req_t bus_req;
  mem_rsp_t bus_rsp;

  lsu_ex_stage u_ex (
    .clk               (clk),
    .rst_n             (rst_n),
    .cmd_valid_i       (cmd_valid_i),
    .cmd_ready_o       (cmd_ready_o),
    .cmd_i             (cmd_i),
    .rsp_valid_o       (rsp_valid_o),
    .rsp_o             (rsp_o),
    .lsu_req_o         (lsu_req),
    .lsu_we_o          (lsu_we),
    .lsu_size_o        (lsu_size),
    .lsu_sign_ext_o    (lsu_sign_ext),
    .lsu_wdata_o       (lsu_wdata),
    .lsu_addr_o        (lsu_addr),
    .lsu_reg_offset_o  (lsu_reg_offset),
    .lsu_update_addr_i (lsu_update_addr),
    .lsu_misaligned_i  (lsu_misaligned),
    .lsu_valid_i       (lsu_valid),
    .lsu_rdata_i       (lsu_rdata)
  );

  lsu_core u_lsu (
    .clk               (clk),
    .rst_n             (rst_n),
    .data_req_i        (lsu_req),
    .data_we_i         (lsu_we),
    .data_size_i       (lsu_size),
    .data_sign_ext_i   (lsu_sign_ext),
    .data_wdata_i      (lsu_wdata),
    .data_addr_i       (lsu_addr),
    .data_reg_offset_i (lsu_reg_offset),
    .update_addr_o     (lsu_update_addr),
    .misaligned_o      (lsu_misaligned),
    .data_valid_o      (lsu_valid),
    .data_rdata_o      (lsu_rdata),
    .bus_req_o         (bus_req),
    .bus_rsp_i         (bus_rsp)
  );

  data_mem u_mem (
    .clk     (clk),
    .rst_n   (rst_n),
    .stall_i (stall_i),
    .req_i   (bus_req),
    .rsp_o   (bus_rsp)
  );

endmodule

// File: verif/lsu_tb_vectors.svh
// rows run in order and every byte a load touches must be written by an earlier store row
`ifndef LSU_TB_VECTORS_SVH
`define LSU_TB_VECTORS_SVH

// one table row
typedef struct packed {
  lsu_pkg::lsu_cmd_t cmd;
  logic              stall_rnd;  // random run of 1 to 3 stalled cycles
  logic [31:0]       exp_rdata;  // zero for stores
} vec_t;

localparam int NUM_VECS = 46;

//////////////////////////////////////////////////
// columns: we, size, sign_ext, base, offset, wdata
// then random stall, expected rdata
//////////////////////////////////////////////////
localparam vec_t VECS [NUM_VECS] = '{
  '{'{1'b1, LSU_WORD,   1'b0, 32'h100, 32'h0,  32'h8899AABB}, 1'b0, 32'h00000000},
  '{'{1'b1, LSU_WORD,   1'b0, 32'h100, 32'h4,  32'h11223344}, 1'b1, 32'h00000000},
  '{'{1'b1, LSU_WORD,   1'b0, 32'h100, 32'h8,  32'hCAFEF00D}, 1'b0, 32'h00000000},
  '{'{1'b1, LSU_WORD,   1'b0, 32'h108, 32'h4,  32'h7F80017E}, 1'b1, 32'h00000000},
  '{'{1'b1, LSU_WORD,   1'b0, 32'h110, 32'h0,  32'hDEADBEEF}, 1'b0, 32'h00000000},
  '{'{1'b1, LSU_WORD,   1'b0, 32'h110, 32'h4,  32'h01234567}, 1'b0, 32'h00000000},
  // aligned word loads
  '{'{1'b0, LSU_WORD,   1'b0, 32'h100, 32'h0,  32'h0},        1'b0, 32'h8899AABB},
  '{'{1'b0, LSU_WORD,   1'b0, 32'h0FC, 32'h8,  32'h0},        1'b1, 32'h11223344},
  // byte loads, every lane, both extensions
  '{'{1'b0, LSU_BYTE,   1'b1, 32'h100, 32'h0,  32'h0},        1'b0, 32'hFFFFFFBB},
  '{'{1'b0, LSU_BYTE,   1'b0, 32'h100, 32'h1,  32'h0},        1'b0, 32'h000000AA},
  '{'{1'b0, LSU_BYTE,   1'b1, 32'h100, 32'h2,  32'h0},        1'b0, 32'hFFFFFF99},
  '{'{1'b0, LSU_BYTE,   1'b0, 32'h100, 32'h3,  32'h0},        1'b0, 32'h00000088},
  '{'{1'b0, LSU_BYTE_X, 1'b1, 32'h10C, 32'h2,  32'h0},        1'b0, 32'hFFFFFF80},
  '{'{1'b0, LSU_BYTE,   1'b1, 32'h10C, 32'h3,  32'h0},        1'b0, 32'h0000007F},
  // half-word loads inside a word
  '{'{1'b0, LSU_HALF,   1'b1, 32'h100, 32'h0,  32'h0},        1'b0, 32'hFFFFAABB},
  '{'{1'b0, LSU_HALF,   1'b0, 32'h100, 32'h1,  32'h0},        1'b0, 32'h000099AA},
  '{'{1'b0, LSU_HALF,   1'b1, 32'h100, 32'h2,  32'h0},        1'b1, 32'hFFFF8899},
  '{'{1'b0, LSU_HALF,   1'b1, 32'h10C, 32'h1,  32'h0},        1'b0, 32'hFFFF8001},
  // narrow stores, then the whole word
  '{'{1'b1, LSU_BYTE,   1'b0, 32'h104, 32'h0,  32'hFFFFFF5A}, 1'b0, 32'h00000000},
  '{'{1'b1, LSU_BYTE,   1'b0, 32'h104, 32'h1,  32'h000000C3}, 1'b0, 32'h00000000},
  '{'{1'b1, LSU_BYTE,   1'b0, 32'h104, 32'h2,  32'h12345677}, 1'b1, 32'h00000000},
  '{'{1'b1, LSU_BYTE,   1'b0, 32'h104, 32'h3,  32'h000000E1}, 1'b0, 32'h00000000},
  '{'{1'b0, LSU_WORD,   1'b0, 32'h104, 32'h0,  32'h0},        1'b0, 32'hE177C35A},
  '{'{1'b1, LSU_HALF,   1'b0, 32'h108, 32'h0,  32'hFFFF1234}, 1'b0, 32'h00000000},
  '{'{1'b1, LSU_HALF,   1'b0, 32'h108, 32'h1,  32'h0000ABCD}, 1'b0, 32'h00000000},
  '{'{1'b1, LSU_HALF,   1'b0, 32'h108, 32'h2,  32'h00005566}, 1'b0, 32'h00000000},
  '{'{1'b0, LSU_WORD,   1'b0, 32'h108, 32'h0,  32'h0},        1'b0, 32'h5566CD34},
  // split words across the boundary
  '{'{1'b1, LSU_WORD,   1'b0, 32'h110, 32'h1,  32'hA1B2C3D4}, 1'b1, 32'h00000000},
  '{'{1'b0, LSU_WORD,   1'b0, 32'h110, 32'h1,  32'h0},        1'b1, 32'hA1B2C3D4},
  '{'{1'b0, LSU_WORD,   1'b0, 32'h114, 32'h0,  32'h0},        1'b0, 32'h012345A1},
  '{'{1'b0, LSU_WORD,   1'b0, 32'h100, 32'h12, 32'h0},        1'b0, 32'h45A1B2C3},
  '{'{1'b0, LSU_WORD,   1'b0, 32'h110, 32'h3,  32'h0},        1'b0, 32'h2345A1B2},
  '{'{1'b1, LSU_WORD,   1'b0, 32'h100, 32'h2,  32'h0F1E2D3C}, 1'b0, 32'h00000000},
  '{'{1'b0, LSU_WORD,   1'b0, 32'h100, 32'h2,  32'h0},        1'b0, 32'h0F1E2D3C},
  '{'{1'b1, LSU_WORD,   1'b0, 32'h100, 32'h3,  32'h6655AA99}, 1'b1, 32'h00000000},
  '{'{1'b0, LSU_WORD,   1'b0, 32'h100, 32'h0,  32'h0},        1'b0, 32'h993CAABB},
  '{'{1'b0, LSU_WORD,   1'b0, 32'h104, 32'h0,  32'h0},        1'b0, 32'hE16655AA},
  // split half words at offset 3
  '{'{1'b1, LSU_HALF,   1'b0, 32'h10C, 32'h3,  32'h0000C0DE}, 1'b0, 32'h00000000},
  '{'{1'b0, LSU_HALF,   1'b1, 32'h10C, 32'h3,  32'h0},        1'b1, 32'hFFFFC0DE},
  '{'{1'b0, LSU_HALF,   1'b0, 32'h10C, 32'h3,  32'h0},        1'b0, 32'h0000C0DE},
  '{'{1'b0, LSU_HALF,   1'b1, 32'h100, 32'h3,  32'h0},        1'b0, 32'hFFFFAA99},
  '{'{1'b1, LSU_HALF,   1'b0, 32'h104, 32'h3,  32'h00007B12}, 1'b0, 32'h00000000},
  '{'{1'b0, LSU_HALF,   1'b1, 32'h104, 32'h3,  32'h0},        1'b0, 32'h00007B12},
  '{'{1'b0, LSU_WORD,   1'b0, 32'h104, 32'h0,  32'h0},        1'b0, 32'h126655AA},
  '{'{1'b0, LSU_WORD,   1'b0, 32'h108, 32'h0,  32'h0},        1'b0, 32'h5566CD7B},
  '{'{1'b0, LSU_BYTE,   1'b1, 32'h110, 32'h0,  32'h0},        1'b0, 32'hFFFFFFC0}
};

`endif

// File: verif/lsu_tb.sv
// addresses stay inside the memory and a stall run only covers the first bus part of a row
module lsu_tb;
  import lsu_pkg::*;
  import mem_bus_pkg::*;

  `include "lsu_tb_vectors.svh"

  localparam int unsigned SHADOW_AW = MEM_AW + 2;  // byte index width
  localparam int RSP_TIMEOUT = 50;                 // cycles per response
  localparam int ACC_TIMEOUT = 10;                 // cycles for cmd_ready_o
  localparam int RNG_SEED    = 99;

  logic     clk;
  logic     rst_n;
  logic     cmd_valid;
  logic     cmd_ready;
  lsu_cmd_t cmd;
  logic     rsp_valid;
  lsu_rsp_t rsp;
  logic     stall;

  logic [7:0] shadow [MEM_WORDS*4];  // expected memory bytes
  int         n_checks;
  int         err_data;
  int         err_hs;                // handshake and latency
  int         err_timeout;
  int         err_table;
  logic       timed_out;

  lsu_subsys_top DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_valid_i (cmd_valid),
    .cmd_ready_o (cmd_ready),
    .cmd_i       (cmd),
    .rsp_valid_o (rsp_valid),
    .rsp_o       (rsp),
    .stall_i     (stall)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////
  function automatic int size_bytes(input lsu_size_e size);
    case (size)
      LSU_WORD: return 4;
      LSU_HALF: return 2;
      default:  return 1;
    endcase
  endfunction

  // word at lane 1..3 or half at lane 3 crosses into the next word
  function automatic logic needs_split(input logic [31:0] addr, input lsu_size_e size);
    case (size)
      LSU_WORD: return addr[1:0] != 2'b00;
      LSU_HALF: return addr[1:0] == 2'b11;
      default:  return 1'b0;
    endcase
  endfunction

  function automatic void shadow_write(input logic [31:0] addr, input lsu_size_e size,
                                       input logic [31:0] wdata);
    logic [SHADOW_AW-1:0] bidx;
    bidx = addr[SHADOW_AW-1:0];
    for (int k = 0; k < size_bytes(size); k++) begin
      shadow[bidx] = wdata[8*k +: 8];  // little endian
      bidx = bidx + 1'b1;
    end
  endfunction

  function automatic logic [31:0] expected_load(input logic [31:0] addr, input lsu_size_e size,
                                                input logic sx);
    logic [SHADOW_AW-1:0] bidx;
    logic [7:0]           b [4];
    logic [31:0]          res;
    bidx = addr[SHADOW_AW-1:0];
    for (int k = 0; k < 4; k++) begin
      b[k] = shadow[bidx];             // bytes past the size are unused
      bidx = bidx + 1'b1;
    end
    case (size)
      LSU_WORD: res = {b[3], b[2], b[1], b[0]};
      LSU_HALF: res = {{16{sx & b[1][7]}}, b[1], b[0]};
      default:  res = {{24{sx & b[0][7]}}, b[0]};
    endcase
    return res;
  endfunction

  //////////////////////////////////////////////////
  // one table row: send, wait, check
  //////////////////////////////////////////////////
  task automatic run_row(input int row);
    vec_t        v;
    logic [31:0] addr;
    logic [31:0] exp_rdata;
    int          stall_left;
    int          exp_lat;
    int          cycles;
    logic        accepted;
    logic        got;
    lsu_rsp_t    got_rsp;
    v          = VECS[row];
    addr       = v.cmd.base + v.cmd.offset;
    stall_left = v.stall_rnd ? 1 + int'($urandom % 3) : 0;
    exp_lat    = (needs_split(addr, v.cmd.size) ? 4 : 2) + stall_left;
    exp_rdata  = v.cmd.we ? 32'h0 : expected_load(addr, v.cmd.size, v.cmd.sign_ext);
    if (exp_rdata !== v.exp_rdata) begin
      err_table++;
      $display("row %0d: table expects %h but the memory model gives %h",
               row, v.exp_rdata, exp_rdata);
    end

    @(posedge clk);
    #5;
    cmd_valid = 1'b1;
    cmd       = v.cmd;
    cycles    = 0;
    accepted  = 1'b0;
    while (!accepted && cycles < ACC_TIMEOUT) begin
      @(negedge clk);
      accepted = cmd_ready;
      if (rsp_valid) begin
        err_hs++;
        $display("row %0d: rsp_valid_o pulsed with no access in flight", row);
      end
      @(posedge clk);
      #5;
      cycles++;
    end
    cmd_valid = 1'b0;
    if (!accepted) begin
      err_timeout++;
      timed_out = 1'b1;
      $display("row %0d: cmd_ready_o stayed low for %0d cycles", row, ACC_TIMEOUT);
      return;
    end

    // back-pressure starts in the cycle after accept
    stall = (stall_left > 0);
    if (stall_left > 0) stall_left--;
    cycles = 0;
    got    = 1'b0;
    while (!got && cycles < RSP_TIMEOUT) begin
      @(negedge clk);
      cycles++;
      if (cmd_ready) begin
        err_hs++;
        $display("row %0d: cmd_ready_o went high before the response", row);
      end
      if (rsp_valid) begin
        got     = 1'b1;
        got_rsp = rsp;
      end
      @(posedge clk);
      #5;
      stall = (stall_left > 0);
      if (stall_left > 0) stall_left--;
    end
    stall = 1'b0;

    if (!got) begin
      err_timeout++;
      timed_out = 1'b1;
      $display("row %0d: no response within %0d cycles", row, RSP_TIMEOUT);
    end else begin
      n_checks = n_checks + 3;
      if (got_rsp.rdata !== exp_rdata) begin
        err_data++;
        $display("Error: row %0d rsp_o.rdata got %h expected %h", row, got_rsp.rdata, exp_rdata);
      end
      if (got_rsp.was_store !== v.cmd.we) begin
        err_data++;
        $display("Error: row %0d rsp_o.was_store got %h expected %h",
                 row, got_rsp.was_store, v.cmd.we);
      end
      if (cycles != exp_lat) begin
        err_hs++;
        $display("Error: row %0d rsp_valid_o latency got %h expected %h", row, cycles, exp_lat);
      end
      if (v.cmd.we) begin
        shadow_write(addr, v.cmd.size, v.cmd.wdata);  // memory now holds the store
      end
    end
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////
  initial begin
    rst_n       = 1'b0;
    cmd_valid   = 1'b0;
    cmd         = '0;
    stall       = 1'b0;
    n_checks    = 0;
    err_data    = 0;
    err_hs      = 0;
    err_timeout = 0;
    err_table   = 0;
    timed_out   = 1'b0;
    void'($urandom(RNG_SEED));
    repeat (10) @(posedge clk);
    #5;
    rst_n = 1'b1;

    @(negedge clk);                   // idle outputs before any command
    n_checks = n_checks + 2;
    if (rsp_valid !== 1'b0) begin
      err_hs++;
      $display("Error: rsp_valid_o after reset got %h expected %h", rsp_valid, 1'b0);
    end
    if (cmd_ready !== 1'b1) begin
      err_hs++;
      $display("Error: cmd_ready_o after reset got %h expected %h", cmd_ready, 1'b1);
    end

    for (int i = 0; i < NUM_VECS && !timed_out; i++) begin
      run_row(i);
    end

    $display("checks %0d, errors: data %0d, handshake %0d, timeout %0d, table %0d",
             n_checks, err_data, err_hs, err_timeout, err_table);
    if (err_data + err_hs + err_timeout + err_table == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: filelist.f
+incdir+verif
hw/lsu_pkg.sv
hw/mem_bus_pkg.sv
hw/lsu_align.sv
hw/lsu_core.sv
hw/lsu_ex_stage.sv
hw/data_mem.sv
hw/lsu_subsys_top.sv
verif/lsu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run, then look for the fail message in the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir "$LOG" &&
verilator --binary --timing -f filelist.f --top-module lsu_tb -o lsu_tb_sim &&
./obj_dir/lsu_tb_sim > "$LOG" 2>&1 ||
{ echo "build or run error, see $LOG"; exit 1; }
cat "$LOG"
! grep -q "Simulation failed" "$LOG" && grep -q "Simulation passed" "$LOG" &&
echo "PASS" || { echo "FAIL"; exit 1; }
